// File: include/afu_guard_settings.svh
// ========================================
// Widths, size limits and CSR offsets of the AFU port guard
// Stream width is fixed to one 64-bit header per first beat
// Size limits are in bytes
// ========================================
`ifndef AFU_GUARD_SETTINGS_SVH
`define AFU_GUARD_SETTINGS_SVH

`define AFG_DATA_W             64
`define AFG_KEEP_W             8
`define AFG_LEN_W              12
`define AFG_BEAT_BYTES_W       ($clog2(`AFG_KEEP_W + 1))

// Payload limits
`define AFG_MAX_PLD_BYTES      256
`define AFG_MAX_RD_REQ_BYTES   512

// AXI4-Lite CSR port
`define AFG_AXIL_ADDR_W        8
`define AFG_AXIL_DATA_W        32
`define AFG_CSR_ERR_STATUS     8'h00
`define AFG_CSR_DROP_COUNT     8'h04

`endif

// File: verilog/afu_guard_pkg.sv
// ========================================
// Types shared by the AFU port guard
// Header sits in tdata[63:0] of the first beat
// Length field is in bytes, not DWords
// ========================================
`default_nettype none

`include "afu_guard_settings.svh"

package afu_guard_pkg;

   // Legal format/type codes on the transmit path
   typedef enum logic [7:0] {
      FMT_MRD  = 8'h20,
      FMT_MWR  = 8'h60,
      FMT_CPLD = 8'h4A
   } tlp_fmt_e;

   // First beat of every packet, top bits first
   typedef struct packed {
      logic [7:0]            fmt_type;   // Raw, may be illegal
      logic [`AFG_LEN_W-1:0] length;     // Bytes
      logic [7:0]            tag;
      logic [3:0]            rsvd;
      logic [31:0]           addr;
   } tlp_hdr_t;

   // Rule violations, bit 4 down to bit 0
   typedef struct packed {
      logic malformed;
      logic max_payload;
      logic max_rd_req;
      logic insufficient_data;
      logic payload_overrun;
   } err_vec_t;

endpackage

`default_nettype wire

// File: verilog/afu_guard_ifs.sv
// ========================================
// Internal interfaces of the AFU port guard
// tx_stream_if is the AFU side of the gate
// tlp_beat_if carries registered beat info
// ========================================
`timescale 1ns/1ps
`default_nettype none

`include "afu_guard_settings.svh"

interface tx_stream_if;
   logic                   tvalid;
   logic                   tready;
   logic                   tlast;
   logic [`AFG_DATA_W-1:0] tdata;
   logic [`AFG_KEEP_W-1:0] tkeep;

   modport gate (
      input  tvalid, tlast, tdata, tkeep,
      output tready
   );

   // Passive tap, sees the handshake
   modport monitor (
      input tvalid, tready, tlast, tdata, tkeep
   );
endinterface

interface tlp_beat_if;
   import afu_guard_pkg::*;

   logic                        beat_valid;
   logic                        sop;
   logic                        eop;
   tlp_hdr_t                    hdr;          // Valid with sop
   logic                        fmt_known;    // Valid with sop
   logic [`AFG_BEAT_BYTES_W-1:0] data_bytes;  // Zero on the header beat

   modport driver (
      output beat_valid, sop, eop, hdr, fmt_known, data_bytes
   );

   modport receiver (
      input beat_valid, sop, eop, hdr, fmt_known, data_bytes
   );
endinterface

`default_nettype wire

// File: verilog/tlp_hdr_decode.sv
// ========================================
// Registers every accepted transmit beat
// beat_valid trails the handshake by one cycle
// Data beats are assumed to hold contiguous low bytes
// ========================================
`timescale 1ns/1ps
`default_nettype none

`include "afu_guard_settings.svh"

module tlp_hdr_decode (
   input  wire logic         clk,
   input  wire logic         rst_n,
   tx_stream_if.monitor      i_tx,
   tlp_beat_if.driver        o_beat
);
   import afu_guard_pkg::*;

   logic                         in_pkt;
   logic                         xfer;
   logic                         sop_now;
   logic                         eop_now;
   tlp_hdr_t                     hdr_now;
   logic [`AFG_BEAT_BYTES_W-1:0] keep_cnt;

   assign xfer    = i_tx.tvalid & i_tx.tready;
   assign sop_now = xfer & ~in_pkt;    // First beat after idle or EOP
   assign eop_now = xfer & i_tx.tlast;
   assign hdr_now = tlp_hdr_t'(i_tx.tdata);

   // Byte count of the beat
   always_comb begin
      keep_cnt = '0;
      for (int i = 0; i < `AFG_KEEP_W; i++) begin
         keep_cnt = keep_cnt + i_tx.tkeep[i];
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         in_pkt <= 1'b0;
      end else if (xfer) begin
         in_pkt <= ~i_tx.tlast;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         o_beat.beat_valid <= 1'b0;
         o_beat.sop        <= 1'b0;
         o_beat.eop        <= 1'b0;
      end else begin
         o_beat.beat_valid <= xfer;
         o_beat.sop        <= sop_now;
         o_beat.eop        <= eop_now;
      end
   end

   always_ff @(posedge clk) begin
      if (sop_now) begin
         o_beat.hdr       <= hdr_now;
         o_beat.fmt_known <= hdr_now.fmt_type inside {FMT_MRD, FMT_MWR, FMT_CPLD};
      end
      if (xfer) begin
         // Header beat carries no payload
         o_beat.data_bytes <= sop_now ? '0 : keep_cnt;
      end
   end

endmodule

`default_nettype wire

// File: verilog/tlp_rule_checker.sv
// ========================================
// Five transmit rules, one pulse per violation
// Header rules at SOP, data rules at EOP
// Malformed packets skip all other rules
// ========================================
`timescale 1ns/1ps
`default_nettype none

`include "afu_guard_settings.svh"

module tlp_rule_checker (
   input  wire logic                  clk,
   input  wire logic                  rst_n,
   tlp_beat_if.receiver               i_beat,
   output afu_guard_pkg::err_vec_t    o_err_set
);
   import afu_guard_pkg::*;

   // One spare bit so a long packet saturates past any legal length
   localparam int CNT_W = `AFG_LEN_W + 1;

   logic [7:0]            pkt_fmt;
   logic [`AFG_LEN_W-1:0] pkt_len;
   logic                  pkt_bad;
   logic [CNT_W-1:0]      byte_cnt;

   logic [7:0]            fmt;
   logic [`AFG_LEN_W-1:0] len;
   logic                  bad;
   logic [CNT_W-1:0]      base;
   logic [CNT_W:0]        sum;
   logic [CNT_W-1:0]      bytes_now;
   logic                  is_mrd;
   logic                  has_data;
   logic                  hdr_chk;
   logic                  end_chk;
   err_vec_t              err_d;

   always_comb begin
      // Header of the current packet, fresh on SOP, held otherwise
      fmt  = i_beat.sop ? i_beat.hdr.fmt_type : pkt_fmt;
      len  = i_beat.sop ? i_beat.hdr.length : pkt_len;
      bad  = i_beat.sop ? ~i_beat.fmt_known : pkt_bad;
      base = i_beat.sop ? '0 : byte_cnt;

      sum       = base + i_beat.data_bytes;
      bytes_now = sum[CNT_W] ? '1 : sum[CNT_W-1:0];

      is_mrd   = (fmt == FMT_MRD);
      has_data = (fmt == FMT_MWR) || (fmt == FMT_CPLD);
      hdr_chk  = i_beat.beat_valid & i_beat.sop;
      end_chk  = i_beat.beat_valid & i_beat.eop & ~bad;

      err_d.malformed   = hdr_chk & bad;
      err_d.max_payload = hdr_chk & ~bad & has_data &
                          ((len == '0) || (len > `AFG_MAX_PLD_BYTES));
      err_d.max_rd_req  = hdr_chk & ~bad & is_mrd & (len > `AFG_MAX_RD_REQ_BYTES);

      err_d.insufficient_data = end_chk & has_data & (bytes_now < len);
      // For a read, an EOP that is not the header means data beats followed
      err_d.payload_overrun   = end_chk & ((has_data & (bytes_now > len)) |
                                           (is_mrd & ~i_beat.sop));
   end

   always_ff @(posedge clk) begin
      if (i_beat.beat_valid) begin
         pkt_fmt  <= fmt;
         pkt_len  <= len;
         pkt_bad  <= bad;
         byte_cnt <= bytes_now;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         o_err_set <= '0;
      end else begin
         o_err_set <= err_d;   // Single-cycle pulses
      end
   end

endmodule

`default_nettype wire

// File: verilog/tx_traffic_gate.sv
// ========================================
// Forwards or drops whole transmit packets
// Decision taken once per packet, at its SOP
// Dropped beats are accepted and never reach the host
// ========================================
`timescale 1ns/1ps
`default_nettype none

`include "afu_guard_settings.svh"

module tx_traffic_gate (
   input  wire logic                   clk,
   input  wire logic                   rst_n,
   tx_stream_if.gate                   i_tx,
   output logic                        o_host_tvalid,
   input  wire logic                   i_host_tready,
   output logic                        o_host_tlast,
   output logic [`AFG_DATA_W-1:0]      o_host_tdata,
   output logic [`AFG_KEEP_W-1:0]      o_host_tkeep,
   input  wire logic                   i_block,
   output logic                        o_drop_pulse
);

   logic in_pkt;     // Beats of a packet already accepted
   logic dec_hold;   // SOP presented but stalled, decision kept
   logic drop_pkt;
   logic drop_now;
   logic xfer;

   // Keep the decision stable while a stalled SOP waits
   assign drop_now = (in_pkt | dec_hold) ? drop_pkt : i_block;

   assign o_host_tvalid = i_tx.tvalid & ~drop_now;
   assign o_host_tlast  = i_tx.tlast;
   assign o_host_tdata  = i_tx.tdata;
   assign o_host_tkeep  = i_tx.tkeep;
   assign i_tx.tready   = drop_now | i_host_tready;   // Sink dropped beats

   assign xfer         = i_tx.tvalid & i_tx.tready;
   assign o_drop_pulse = xfer & ~in_pkt & drop_now;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         in_pkt   <= 1'b0;
         dec_hold <= 1'b0;
         drop_pkt <= 1'b0;
      end else begin
         if (xfer) begin
            in_pkt <= ~i_tx.tlast;
         end
         if (!in_pkt && i_tx.tvalid) begin
            drop_pkt <= drop_now;
            dec_hold <= ~i_tx.tready;
         end
      end
   end

endmodule

`default_nettype wire

// File: verilog/err_csr_axil.sv
// ========================================
// AXI4-Lite slave with sticky error bits
// ERR_STATUS is write-1-to-clear, set wins
// DROP_COUNT is read-only and wraps
// Single outstanding read and write, always OKAY
// ========================================
`timescale 1ns/1ps
`default_nettype none

`include "afu_guard_settings.svh"

module err_csr_axil (
   input  wire logic                        clk,
   input  wire logic                        rst_n,
   input  wire logic                        i_s_awvalid,
   output logic                             o_s_awready,
   input  wire logic [`AFG_AXIL_ADDR_W-1:0] i_s_awaddr,
   input  wire logic                        i_s_wvalid,
   output logic                             o_s_wready,
   input  wire logic [`AFG_AXIL_DATA_W-1:0] i_s_wdata,
   output logic                             o_s_bvalid,
   input  wire logic                        i_s_bready,
   output logic [1:0]                       o_s_bresp,
   input  wire logic                        i_s_arvalid,
   output logic                             o_s_arready,
   input  wire logic [`AFG_AXIL_ADDR_W-1:0] i_s_araddr,
   output logic                             o_s_rvalid,
   input  wire logic                        i_s_rready,
   output logic [`AFG_AXIL_DATA_W-1:0]      o_s_rdata,
   output logic [1:0]                       o_s_rresp,
   input  wire afu_guard_pkg::err_vec_t     i_err_set,
   input  wire logic                        i_drop_pulse,
   output logic                             o_blocking
);

   localparam int ERR_W = $bits(i_err_set);

   logic [ERR_W-1:0]            err_q;
   logic [ERR_W-1:0]            err_clr;
   logic [31:0]                 drop_cnt;
   logic                        wr_en;
   logic                        rd_en;
   logic [`AFG_AXIL_DATA_W-1:0] rd_data;

   // Address and data accepted together
   assign wr_en       = i_s_awvalid & i_s_wvalid & ~o_s_bvalid;
   assign o_s_awready = wr_en;
   assign o_s_wready  = wr_en;
   assign o_s_bresp   = 2'b00;

   assign rd_en       = i_s_arvalid & ~o_s_rvalid;
   assign o_s_arready = rd_en;
   assign o_s_rresp   = 2'b00;

   assign err_clr = (wr_en && (i_s_awaddr == `AFG_CSR_ERR_STATUS)) ?
                    i_s_wdata[ERR_W-1:0] : '0;

   assign o_blocking = |err_q;

   always_comb begin
      case (i_s_araddr)
         `AFG_CSR_ERR_STATUS: rd_data = {{(`AFG_AXIL_DATA_W-ERR_W){1'b0}}, err_q};
         `AFG_CSR_DROP_COUNT: rd_data = drop_cnt;
         default:             rd_data = '0;   // Unmapped
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         err_q    <= '0;
         drop_cnt <= '0;
      end else begin
         err_q <= (err_q & ~err_clr) | i_err_set;   // New errors beat the clear
         if (i_drop_pulse) begin
            drop_cnt <= drop_cnt + 32'd1;
         end
      end
   end

   // Write response
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         o_s_bvalid <= 1'b0;
      end else if (wr_en) begin
         o_s_bvalid <= 1'b1;
      end else if (i_s_bready) begin
         o_s_bvalid <= 1'b0;
      end
   end

   // Read response
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         o_s_rvalid <= 1'b0;
      end else if (rd_en) begin
         o_s_rvalid <= 1'b1;
      end else if (i_s_rready) begin
         o_s_rvalid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (rd_en) begin
         o_s_rdata <= rd_data;
      end
   end

endmodule

`default_nettype wire

// File: verilog/afu_port_guard.sv
// ========================================
// Guard between an AFU and a PCIe host port
// Receive path is a straight pass-through
// Transmit blocks three cycles after a rule hit
// ========================================
`timescale 1ns/1ps
`default_nettype none

`include "afu_guard_settings.svh"

module afu_port_guard (
   input  wire logic                        clk,
   input  wire logic                        rst_n,
   // AFU to host
   input  wire logic                        i_afu_tvalid,
   output logic                             o_afu_tready,
   input  wire logic                        i_afu_tlast,
   input  wire logic [`AFG_DATA_W-1:0]      i_afu_tdata,
   input  wire logic [`AFG_KEEP_W-1:0]      i_afu_tkeep,
   output logic                             o_host_tvalid,
   input  wire logic                        i_host_tready,
   output logic                             o_host_tlast,
   output logic [`AFG_DATA_W-1:0]           o_host_tdata,
   output logic [`AFG_KEEP_W-1:0]           o_host_tkeep,
   // Host to AFU
   input  wire logic                        i_hrx_tvalid,
   output logic                             o_hrx_tready,
   input  wire logic                        i_hrx_tlast,
   input  wire logic [`AFG_DATA_W-1:0]      i_hrx_tdata,
   input  wire logic [`AFG_KEEP_W-1:0]      i_hrx_tkeep,
   output logic                             o_arx_tvalid,
   input  wire logic                        i_arx_tready,
   output logic                             o_arx_tlast,
   output logic [`AFG_DATA_W-1:0]           o_arx_tdata,
   output logic [`AFG_KEEP_W-1:0]           o_arx_tkeep,
   // CSR port
   input  wire logic                        i_s_awvalid,
   output logic                             o_s_awready,
   input  wire logic [`AFG_AXIL_ADDR_W-1:0] i_s_awaddr,
   input  wire logic                        i_s_wvalid,
   output logic                             o_s_wready,
   input  wire logic [`AFG_AXIL_DATA_W-1:0] i_s_wdata,
   output logic                             o_s_bvalid,
   input  wire logic                        i_s_bready,
   output logic [1:0]                       o_s_bresp,
   input  wire logic                        i_s_arvalid,
   output logic                             o_s_arready,
   input  wire logic [`AFG_AXIL_ADDR_W-1:0] i_s_araddr,
   output logic                             o_s_rvalid,
   input  wire logic                        i_s_rready,
   output logic [`AFG_AXIL_DATA_W-1:0]      o_s_rdata,
   output logic [1:0]                       o_s_rresp,
   output logic                             o_blocking
);
   import afu_guard_pkg::*;

   err_vec_t err_set;
   logic     drop_pulse;

   tx_stream_if tx_if ();
   tlp_beat_if  beat_if ();

   // Receive path untouched
   assign o_arx_tvalid = i_hrx_tvalid;
   assign o_arx_tlast  = i_hrx_tlast;
   assign o_arx_tdata  = i_hrx_tdata;
   assign o_arx_tkeep  = i_hrx_tkeep;
   assign o_hrx_tready = i_arx_tready;

   assign tx_if.tvalid = i_afu_tvalid;
   assign tx_if.tlast  = i_afu_tlast;
   assign tx_if.tdata  = i_afu_tdata;
   assign tx_if.tkeep  = i_afu_tkeep;
   assign o_afu_tready = tx_if.tready;

   tx_traffic_gate u_gate (
      .clk           (clk),
      .rst_n         (rst_n),
      .i_tx          (tx_if.gate),
      .o_host_tvalid (o_host_tvalid),
      .i_host_tready (i_host_tready),
      .o_host_tlast  (o_host_tlast),
      .o_host_tdata  (o_host_tdata),
      .o_host_tkeep  (o_host_tkeep),
      .i_block       (o_blocking),
      .o_drop_pulse  (drop_pulse)
   );

   tlp_hdr_decode u_decode (
      .clk    (clk),
      .rst_n  (rst_n),
      .i_tx   (tx_if.monitor),
      .o_beat (beat_if.driver)
   );

   tlp_rule_checker u_checker (
      .clk       (clk),
      .rst_n     (rst_n),
      .i_beat    (beat_if.receiver),
      .o_err_set (err_set)
   );

   err_csr_axil u_csr (
      .clk          (clk),
      .rst_n        (rst_n),
      .i_s_awvalid  (i_s_awvalid),
      .o_s_awready  (o_s_awready),
      .i_s_awaddr   (i_s_awaddr),
      .i_s_wvalid   (i_s_wvalid),
      .o_s_wready   (o_s_wready),
      .i_s_wdata    (i_s_wdata),
      .o_s_bvalid   (o_s_bvalid),
      .i_s_bready   (i_s_bready),
      .o_s_bresp    (o_s_bresp),
      .i_s_arvalid  (i_s_arvalid),
      .o_s_arready  (o_s_arready),
      .i_s_araddr   (i_s_araddr),
      .o_s_rvalid   (o_s_rvalid),
      .i_s_rready   (i_s_rready),
      .o_s_rdata    (o_s_rdata),
      .o_s_rresp    (o_s_rresp),
      .i_err_set    (err_set),
      .i_drop_pulse (drop_pulse),
      .o_blocking   (o_blocking)
   );

endmodule

`default_nettype wire

// File: sim/tb_afu_port_guard.sv
// ========================================
// Table-driven testbench for the AFU port guard
// Host tready is randomized from a fixed seed
// Dropped packets still go through the rule checks
// ========================================
`timescale 1ns/1ps
`default_nettype none

`include "afu_guard_settings.svh"

module tb_afu_port_guard;
   import afu_guard_pkg::*;

   localparam int NROWS     = 13;
   localparam int MAX_BEATS = 65;   // Header plus 64 data beats
   localparam int WD_CYCLES = NROWS * (MAX_BEATS * 4 + 40);
   localparam int BEAT_W    = 1 + `AFG_KEEP_W + `AFG_DATA_W;

   logic                        clk;
   logic                        rst_n;
   logic                        i_afu_tvalid;
   logic                        o_afu_tready;
   logic                        i_afu_tlast;
   logic [`AFG_DATA_W-1:0]      i_afu_tdata;
   logic [`AFG_KEEP_W-1:0]      i_afu_tkeep;
   logic                        o_host_tvalid;
   logic                        i_host_tready;
   logic                        o_host_tlast;
   logic [`AFG_DATA_W-1:0]      o_host_tdata;
   logic [`AFG_KEEP_W-1:0]      o_host_tkeep;
   logic                        i_hrx_tvalid;
   logic                        o_hrx_tready;
   logic                        i_hrx_tlast;
   logic [`AFG_DATA_W-1:0]      i_hrx_tdata;
   logic [`AFG_KEEP_W-1:0]      i_hrx_tkeep;
   logic                        o_arx_tvalid;
   logic                        i_arx_tready;
   logic                        o_arx_tlast;
   logic [`AFG_DATA_W-1:0]      o_arx_tdata;
   logic [`AFG_KEEP_W-1:0]      o_arx_tkeep;
   logic                        i_s_awvalid;
   logic                        o_s_awready;
   logic [`AFG_AXIL_ADDR_W-1:0] i_s_awaddr;
   logic                        i_s_wvalid;
   logic                        o_s_wready;
   logic [`AFG_AXIL_DATA_W-1:0] i_s_wdata;
   logic                        o_s_bvalid;
   logic                        i_s_bready;
   logic [1:0]                  o_s_bresp;
   logic                        i_s_arvalid;
   logic                        o_s_arready;
   logic [`AFG_AXIL_ADDR_W-1:0] i_s_araddr;
   logic                        o_s_rvalid;
   logic                        i_s_rready;
   logic [`AFG_AXIL_DATA_W-1:0] o_s_rdata;
   logic [1:0]                  o_s_rresp;
   logic                        o_blocking;

   // One packet per row
   logic [7:0]            fmt_tab   [NROWS];
   logic [`AFG_LEN_W-1:0] len_tab   [NROWS];
   int                    beats_tab [NROWS];   // Data beats after the header
   int                    keep_tab  [NROWS];   // Bytes in the last data beat
   logic                  fwd_tab   [NROWS];
   logic [4:0]            err_tab   [NROWS];   // ERR_STATUS after the packet
   logic [4:0]            clr_tab   [NROWS];   // W1C mask written afterwards

   logic [BEAT_W-1:0] exp_q[$];
   logic [BEAT_W-1:0] got_q[$];
   logic [BEAT_W-1:0] held_beat;
   logic              stalled;
   logic [31:0]       drop_exp;
   integer            seed;
   int                errors;
   int                beats_seen;

   afu_port_guard dut (.*);

   always #5 clk = ~clk;

   task automatic report_mismatch(input string name, input logic [127:0] got,
                                  input logic [127:0] exp);
      errors++;
      $display("ERROR at %0t ns: %s expected 0x%0h got 0x%0h", $time, name, exp, got);
   endtask

   task automatic set_row(input int r, input logic [7:0] fmt, input logic [11:0] len,
                          input int beats, input int last_keep, input logic fwd,
                          input logic [4:0] err, input logic [4:0] clr);
      fmt_tab[r]   = fmt;
      len_tab[r]   = len;
      beats_tab[r] = beats;
      keep_tab[r]  = last_keep;
      fwd_tab[r]   = fwd;
      err_tab[r]   = err;
      clr_tab[r]   = clr;
   endtask

   task automatic load_table();
      set_row(0,  FMT_MRD,  64,   0,  0, 1'b1, 5'h00, 5'h00);
      set_row(1,  FMT_MWR,  20,   3,  4, 1'b1, 5'h00, 5'h00);
      set_row(2,  FMT_CPLD, 16,   2,  8, 1'b1, 5'h00, 5'h00);
      set_row(3,  8'h33,    8,    1,  8, 1'b1, 5'h10, 5'h00);  // Malformed
      set_row(4,  FMT_MWR,  8,    1,  8, 1'b0, 5'h10, 5'h10);
      set_row(5,  FMT_MWR,  512,  64, 8, 1'b1, 5'h08, 5'h08);  // Max payload
      set_row(6,  FMT_MRD,  1024, 0,  0, 1'b1, 5'h04, 5'h04);  // Max read request
      set_row(7,  FMT_MWR,  32,   2,  8, 1'b1, 5'h02, 5'h00);  // Short write
      set_row(8,  FMT_MWR,  8,    2,  8, 1'b0, 5'h03, 5'h01);  // Overrun while blocked
      set_row(9,  FMT_CPLD, 8,    1,  8, 1'b0, 5'h02, 5'h02);
      set_row(10, FMT_MWR,  16,   2,  8, 1'b1, 5'h00, 5'h00);
      set_row(11, FMT_MRD,  32,   1,  4, 1'b1, 5'h01, 5'h01);  // Read with data
      set_row(12, FMT_MRD,  32,   0,  0, 1'b1, 5'h00, 5'h00);
   endtask

   // Called just after a rising edge, returns just after the transfer edge
   task automatic send_beat(input logic [63:0] data, input logic [7:0] keep,
                            input logic last, input logic fwd);
      logic done;
      done = 1'b0;
      i_afu_tvalid <= 1'b1;
      i_afu_tdata  <= data;
      i_afu_tkeep  <= keep;
      i_afu_tlast  <= last;
      if (fwd) begin
         exp_q.push_back({last, keep, data});
      end
      while (!done) begin
         @(negedge clk);
         done = o_afu_tready;
         if (!fwd && !o_afu_tready) begin
            report_mismatch("o_afu_tready", o_afu_tready, 1'b1);
         end
         @(posedge clk);
         i_host_tready <= $random(seed);
      end
   endtask

   task automatic send_packet(input int r);
      logic [63:0] hdr;
      logic [63:0] data;
      logic [7:0]  keep;
      int          nb;
      nb  = beats_tab[r];
      hdr = {fmt_tab[r], len_tab[r], 8'(r), 4'h0, 32'h1000_0000 + 32'(r) * 32'h100};
      send_beat(hdr, 8'hFF, nb == 0, fwd_tab[r]);
      for (int i = 0; i < nb; i++) begin
         data = {$random(seed), $random(seed)};
         keep = (i == nb - 1) ? (8'hFF >> (8 - keep_tab[r])) : 8'hFF;
         send_beat(data, keep, i == nb - 1, fwd_tab[r]);
      end
      i_afu_tvalid <= 1'b0;
   endtask

   task automatic compare_host_beats(input int r);
      if (got_q.size() != exp_q.size()) begin
         errors++;
         $display("ERROR at %0t ns: row %0d put %0d beats on the host port instead of %0d",
                  $time, r, got_q.size(), exp_q.size());
      end else begin
         foreach (exp_q[i]) begin
            beats_seen++;
            if (got_q[i] != exp_q[i]) begin
               report_mismatch("host {tlast,tkeep,tdata}", got_q[i], exp_q[i]);
            end
         end
      end
      exp_q.delete();
      got_q.delete();
   endtask

   task automatic axil_read(input logic [7:0] addr, output logic [31:0] data);
      logic done;
      done = 1'b0;
      i_s_arvalid <= 1'b1;
      i_s_araddr  <= addr;
      while (!done) begin
         @(negedge clk);
         done = o_s_arready;
         @(posedge clk);
      end
      i_s_arvalid <= 1'b0;
      i_s_rready  <= 1'b1;
      done = 1'b0;
      while (!done) begin
         @(negedge clk);
         done = o_s_rvalid;
         data = o_s_rdata;
         if (done && o_s_rresp != 2'b00) begin
            report_mismatch("o_s_rresp", o_s_rresp, 2'b00);
         end
         @(posedge clk);
      end
      i_s_rready <= 1'b0;
   endtask

   task automatic axil_write(input logic [7:0] addr, input logic [31:0] data);
      logic done;
      done = 1'b0;
      i_s_awvalid <= 1'b1;
      i_s_wvalid  <= 1'b1;
      i_s_awaddr  <= addr;
      i_s_wdata   <= data;
      while (!done) begin
         @(negedge clk);
         done = o_s_awready & o_s_wready;
         @(posedge clk);
      end
      i_s_awvalid <= 1'b0;
      i_s_wvalid  <= 1'b0;
      i_s_bready  <= 1'b1;
      done = 1'b0;
      while (!done) begin
         @(negedge clk);
         done = o_s_bvalid;
         if (done && o_s_bresp != 2'b00) begin
            report_mismatch("o_s_bresp", o_s_bresp, 2'b00);
         end
         @(posedge clk);
      end
      i_s_bready <= 1'b0;
   endtask

   task automatic check_blocking(input logic exp);
      @(negedge clk);
      if (o_blocking != exp) begin
         report_mismatch("o_blocking", o_blocking, exp);
      end
      @(posedge clk);
   endtask

   // Receive path is combinational, checked mid-cycle
   task automatic check_rx_path();
      logic [63:0] data;
      logic [7:0]  keep;
      logic        valid;
      logic        last;
      logic        ready;
      for (int i = 0; i < 6; i++) begin
         data  = {$random(seed), $random(seed)};
         keep  = $random(seed);
         valid = $random(seed);
         last  = $random(seed);
         ready = $random(seed);
         i_hrx_tvalid <= valid;
         i_hrx_tdata  <= data;
         i_hrx_tkeep  <= keep;
         i_hrx_tlast  <= last;
         i_arx_tready <= ready;
         @(negedge clk);
         if (o_arx_tvalid != valid) begin
            report_mismatch("o_arx_tvalid", o_arx_tvalid, valid);
         end
         if (o_arx_tdata != data || o_arx_tkeep != keep || o_arx_tlast != last) begin
            report_mismatch("o_arx {tlast,tkeep,tdata}",
                            {o_arx_tlast, o_arx_tkeep, o_arx_tdata},
                            {last, keep, data});
         end
         if (o_hrx_tready != ready) begin
            report_mismatch("o_hrx_tready", o_hrx_tready, ready);
         end
         @(posedge clk);
      end
   endtask

   // Host side monitor, also checks beats held under back-pressure
   always @(negedge clk) begin
      if (rst_n && stalled && o_host_tvalid &&
          held_beat != {o_host_tlast, o_host_tkeep, o_host_tdata}) begin
         report_mismatch("stalled host beat", {o_host_tlast, o_host_tkeep, o_host_tdata},
                         held_beat);
      end
      if (rst_n && stalled && !o_host_tvalid) begin
         errors++;
         $display("ERROR at %0t ns: host tvalid dropped while the beat was stalled", $time);
      end
      if (rst_n && o_host_tvalid && i_host_tready) begin
         got_q.push_back({o_host_tlast, o_host_tkeep, o_host_tdata});
      end
      stalled   = rst_n & o_host_tvalid & ~i_host_tready;
      held_beat = {o_host_tlast, o_host_tkeep, o_host_tdata};
   end

   initial begin : main_seq
      logic [31:0] rd;
      logic [4:0]  left;
      seed = 21;
      errors = 0;
      beats_seen = 0;
      drop_exp = '0;
      stalled = 1'b0;
      clk = 1'b0;
      rst_n = 1'b0;
      i_afu_tvalid = 1'b0;
      i_afu_tlast = 1'b0;
      i_afu_tdata = '0;
      i_afu_tkeep = '0;
      i_host_tready = 1'b1;
      i_hrx_tvalid = 1'b0;
      i_hrx_tlast = 1'b0;
      i_hrx_tdata = '0;
      i_hrx_tkeep = '0;
      i_arx_tready = 1'b0;
      i_s_awvalid = 1'b0;
      i_s_awaddr = '0;
      i_s_wvalid = 1'b0;
      i_s_wdata = '0;
      i_s_bready = 1'b0;
      i_s_arvalid = 1'b0;
      i_s_araddr = '0;
      i_s_rready = 1'b0;
      load_table();
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);

      for (int r = 0; r < NROWS; r++) begin
         send_packet(r);
         i_host_tready <= 1'b1;
         repeat (4) @(posedge clk);   // Let the rule pipeline settle
         compare_host_beats(r);
         if (!fwd_tab[r]) begin
            drop_exp = drop_exp + 32'd1;
         end
         axil_read(`AFG_CSR_ERR_STATUS, rd);
         if (rd != {27'd0, err_tab[r]}) begin
            report_mismatch("ERR_STATUS", rd, err_tab[r]);
         end
         check_blocking(err_tab[r] != 5'h00);
         axil_read(`AFG_CSR_DROP_COUNT, rd);
         if (rd != drop_exp) begin
            report_mismatch("DROP_COUNT", rd, drop_exp);
         end
         if (clr_tab[r] != 5'h00) begin
            axil_write(`AFG_CSR_ERR_STATUS, {27'd0, clr_tab[r]});
            left = err_tab[r] & ~clr_tab[r];
            axil_read(`AFG_CSR_ERR_STATUS, rd);
            if (rd != {27'd0, left}) begin
               report_mismatch("ERR_STATUS after clear", rd, left);
            end
            check_blocking(left != 5'h00);
         end
      end

      axil_read(8'h08, rd);   // Unmapped
      if (rd != 32'd0) begin
         report_mismatch("unmapped read data", rd, 32'd0);
      end
      axil_write(`AFG_CSR_DROP_COUNT, 32'hDEAD_BEEF);
      axil_read(`AFG_CSR_DROP_COUNT, rd);
      if (rd != drop_exp) begin
         report_mismatch("DROP_COUNT after write", rd, drop_exp);
      end
      check_rx_path();

      $display("Rows run: %0d, host beats compared: %0d, errors: %0d",
               NROWS, beats_seen, errors);
      if (errors == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

   initial begin : watchdog
      repeat (WD_CYCLES) @(posedge clk);
      $display("Timeout: the run did not finish within %0d clock cycles", WD_CYCLES);
      $display("Errors found");
      $finish;
   end

endmodule

`default_nettype wire

// File: list.f
+incdir+include
verilog/afu_guard_pkg.sv
verilog/afu_guard_ifs.sv
verilog/tlp_hdr_decode.sv
verilog/tlp_rule_checker.sv
verilog/tx_traffic_gate.sv
verilog/err_csr_axil.sv
verilog/afu_port_guard.sv
sim/tb_afu_port_guard.sv
